//--- design/cell_bank_ram.sv
//////////////////////////////
// two banks of LIFE_DEPTH rows, registered read, sync write
// front/back selection is the top address bit
//////////////////////////////
`include "life_settings.svh"

module cell_bank_ram (
	input logic     clk,
	row_mem_if.mem  mem
);
	import life_pkg::*;

	// bank 0 rows 0..DEPTH-1, bank 1 above
	row_t ram [0:2*`LIFE_DEPTH-1];

	// flat index from {bank, row}
	function automatic int unsigned flat_idx(input mem_addr_t a);
		int unsigned row_i;
		row_i = a[`LIFE_ADDR_BITS-1:0];
		return a[`LIFE_ADDR_BITS] ? row_i + `LIFE_DEPTH : row_i;
	endfunction

	//////////////////////////////
	// write port
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (mem.we) begin
			ram[flat_idx(mem.waddr)] <= mem.wdata; // one full row per edge
		end
	end

	//////////////////////////////
	// read port
	//////////////////////////////
	// q register, old data on a same-address collision
	always_ff @(posedge clk) begin
		mem.rdata <= ram[flat_idx(mem.raddr)];
	end

endmodule

//--- design/life_pkg.sv
//////////////////////////////
// shared types for the row-streaming life engine
// rtl files pull these in with a wildcard import
//////////////////////////////
`include "life_settings.svh"

package life_pkg;

	// one board row, bit n is column n
	typedef logic [`LIFE_WIDTH-1:0] row_t;

	// row index inside one bank
	typedef logic [`LIFE_ADDR_BITS-1:0] row_addr_t;

	// {bank, row} as seen by the row memory
	typedef logic [`LIFE_ADDR_BITS:0] mem_addr_t;

	// vertical three-cell tally, max 3
	typedef logic [1:0] count3_t;

	// 3x3 tally incl. center cell, max 9
	typedef logic [3:0] count9_t;

	// generation counter
	typedef logic [`LIFE_GEN_BITS-1:0] gen_count_t;

	// pass sequencer FSM
	typedef enum logic [1:0] {
		IDLE   = 2'd0, // host owns the front bank
		STREAM = 2'd1, // wrapped row reads in flight
		FLUSH  = 2'd2  // last write-backs draining
	} pass_state_e;

endpackage

//--- design/life_row_update.sv
//////////////////////////////
// three-row window and toroidal life rule for one full row
// window shifts on shift, result row registered one cycle later
//////////////////////////////
`include "life_settings.svh"

module life_row_update (
	input  logic           clk,
	input  logic           rst_n,
	row_mem_if.tap         mem,
	input  logic           shift,
	output life_pkg::row_t next_row
);
	import life_pkg::*;

	row_t    win_top;  // oldest row, above
	row_t    win_mid;  // row being updated
	row_t    win_bot;  // newest row, below
	logic    shift_q;  // window just moved
	count3_t col_sum [`LIFE_WIDTH];
	count9_t blk_sum [`LIFE_WIDTH];
	row_t    life_row;

	//////////////////////////////
	// row window
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (shift) begin
			win_top <= win_mid;
			win_mid <= win_bot;
			win_bot <= mem.rdata; // read data from the previous cycle's address
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			shift_q <= 1'b0;
		end else begin
			shift_q <= shift;
		end
	end

	//////////////////////////////
	// neighbour tally
	//////////////////////////////
	// vertical 1x3 per column
	always_comb begin
		for (int c = 0; c < `LIFE_WIDTH; c++) begin
			col_sum[c] = {1'b0, win_top[c]} + {1'b0, win_mid[c]} + {1'b0, win_bot[c]};
		end
	end

	// horizontal sum of three column tallies, wraps at both edges
	always_comb begin
		for (int c = 0; c < `LIFE_WIDTH; c++) begin
			int lft;
			int rgt;
			lft = (c == 0) ? `LIFE_WIDTH - 1 : c - 1;
			rgt = (c == `LIFE_WIDTH - 1) ? 0 : c + 1;
			blk_sum[c] = {2'b00, col_sum[lft]} + {2'b00, col_sum[c]} + {2'b00, col_sum[rgt]};
		end
	end

	//////////////////////////////
	// life rule
	//////////////////////////////
	// 9-sum includes the center: 3 -> alive, 4 -> keep current state
	always_comb begin
		for (int c = 0; c < `LIFE_WIDTH; c++) begin
			life_row[c] = (blk_sum[c] == 4'd3) || (win_mid[c] && (blk_sum[c] == 4'd4));
		end
	end

	always_ff @(posedge clk) begin
		if (shift_q) begin
			next_row <= life_row; // write-back data for the middle row
		end
	end

endmodule

//--- design/life_top.sv
//////////////////////////////
// life engine top, host load/step/readback of one toroidal board
// sequencer, row memory and row update around one memory bundle
//////////////////////////////
module life_top (
	input  logic                 clk,
	input  logic                 rst_n,
	// control
	input  logic                 step,      // start one generation
	output logic                 busy,
	output logic                 done,      // 1 cycle, pass finished
	output life_pkg::gen_count_t gen_count,
	// host write, front bank
	input  logic                 wr_en,
	input  life_pkg::row_addr_t  wr_addr,
	input  life_pkg::row_t       wr_data,
	// host read, front bank
	input  logic                 rd_en,
	input  life_pkg::row_addr_t  rd_addr,
	output logic                 rd_valid,
	output life_pkg::row_t       rd_data
);
	import life_pkg::*;

	row_mem_if mem_bus (); // row memory port bundle

	logic shift;    // window shift strobe
	row_t next_row; // updated row for write-back

	//////////////////////////////
	// pass control
	//////////////////////////////
	pass_sequencer u_seq (
		.clk       (clk),
		.rst_n     (rst_n),
		.step      (step),
		.busy      (busy),
		.done      (done),
		.gen_count (gen_count),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.rd_en     (rd_en),
		.rd_addr   (rd_addr),
		.rd_valid  (rd_valid),
		.rd_data   (rd_data),
		.mem       (mem_bus.ctrl),
		.shift     (shift),
		.next_row  (next_row)
	);

	//////////////////////////////
	// board storage
	//////////////////////////////
	cell_bank_ram u_ram (
		.clk (clk),
		.mem (mem_bus.mem)
	);

	//////////////////////////////
	// datapath
	//////////////////////////////
	life_row_update u_row (
		.clk      (clk),
		.rst_n    (rst_n),
		.mem      (mem_bus.tap), // snoops rdata only
		.shift    (shift),
		.next_row (next_row)
	);

endmodule

//--- design/pass_sequencer.sv
//////////////////////////////
// pass control: host access while idle, row streaming while busy
// one accepted step = one generation, banks swap on done
//////////////////////////////
`include "life_settings.svh"

module pass_sequencer (
	input  logic                 clk,
	input  logic                 rst_n,
	// control
	input  logic                 step,
	output logic                 busy,
	output logic                 done,
	output life_pkg::gen_count_t gen_count,
	// host write
	input  logic                 wr_en,
	input  life_pkg::row_addr_t  wr_addr,
	input  life_pkg::row_t       wr_data,
	// host read
	input  logic                 rd_en,
	input  life_pkg::row_addr_t  rd_addr,
	output logic                 rd_valid,
	output life_pkg::row_t       rd_data,
	// memory and row window
	row_mem_if.ctrl              mem,
	output logic                 shift,
	input  life_pkg::row_t       next_row
);
	import life_pkg::*;

	localparam int        LAST_RD  = `LIFE_DEPTH + 1;          // reads 0..DEPTH+1
	localparam row_addr_t LAST_ROW = row_addr_t'(`LIFE_DEPTH - 1);

	pass_state_e              state;
	logic                     front;     // bank with the current board
	logic [`LIFE_ADDR_BITS:0] rd_cnt;    // read index within the pass
	row_addr_t                rd_row;    // wrapped row for rd_cnt
	logic                     rd_fire;   // engine read this cycle
	logic                     wb_fire;   // this read completes a window
	logic [2:0]               wb_d;      // write-back flag delay line
	row_addr_t                wrow_d [3]; // write row delay line
	logic                     last_wr;

	assign busy    = (state != IDLE);
	assign rd_data = mem.rdata; // host read data, qualified by rd_valid

	//////////////////////////////
	// read index -> row address
	//////////////////////////////
	// order is DEPTH-1, 0, 1 .. DEPTH-1, 0
	always_comb begin
		if (rd_cnt == '0) begin
			rd_row = LAST_ROW;       // row above row 0
		end else if (rd_cnt == LAST_RD[`LIFE_ADDR_BITS:0]) begin
			rd_row = '0;             // row below the last row
		end else begin
			rd_row = row_addr_t'(rd_cnt - 1'b1);
		end
	end

	assign rd_fire = (state == STREAM);
	assign wb_fire = rd_fire && (rd_cnt >= 2'd2); // third row of a window

	//////////////////////////////
	// delay line, read -> shift -> write
	//////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			shift <= 1'b0;
			wb_d  <= '0;
		end else begin
			shift <= rd_fire;              // lines up with rdata
			wb_d  <= {wb_d[1:0], wb_fire}; // 3 cycles, matches next_row
		end
	end

	// write row = middle row of that window = read index - 2
	always_ff @(posedge clk) begin
		wrow_d[0] <= row_addr_t'(rd_cnt - 2'd2);
		wrow_d[1] <= wrow_d[0];
		wrow_d[2] <= wrow_d[1];
	end

	assign last_wr = wb_d[2] && (wrow_d[2] == LAST_ROW);

	//////////////////////////////
	// FSM, bank and generation
	//////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= IDLE;
			rd_cnt    <= '0;
			front     <= 1'b0;
			gen_count <= '0;
			done      <= 1'b0;
			rd_valid  <= 1'b0;
		end else begin
			done     <= 1'b0;
			rd_valid <= rd_en && (state == IDLE); // read latency is one cycle
			case (state)
				IDLE: begin
					if (step) begin
						state  <= STREAM;
						rd_cnt <= '0;
					end
				end
				STREAM: begin
					if (rd_cnt == LAST_RD[`LIFE_ADDR_BITS:0]) begin
						state <= FLUSH; // hold rd_cnt, reads are don't care now
					end else begin
						rd_cnt <= rd_cnt + 1'b1;
					end
				end
				FLUSH: begin
					if (last_wr) begin
						state     <= IDLE;
						front     <= ~front;            // back bank now current
						gen_count <= gen_count + 1'b1;
						done      <= 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	//////////////////////////////
	// memory port mux
	//////////////////////////////
	always_comb begin
		if (state == IDLE) begin
			// host sees the front bank only
			mem.raddr = {front, rd_addr};
			mem.waddr = {front, wr_addr};
			mem.wdata = wr_data;
			mem.we    = wr_en;
		end else begin
			mem.raddr = {front, rd_row};      // stream from current board
			mem.waddr = {~front, wrow_d[2]};  // results into back bank
			mem.wdata = next_row;
			mem.we    = wb_d[2];
		end
	end

endmodule

//--- design/row_mem_if.sv
//////////////////////////////
// port bundle of the double-banked row memory
// one read port (1 cycle latency) and one write port
//////////////////////////////
interface row_mem_if;
	import life_pkg::*;

	mem_addr_t raddr; // {bank, row}, sampled every cycle
	row_t      rdata; // valid the cycle after raddr
	mem_addr_t waddr; // {bank, row}
	row_t      wdata;
	logic      we;    // write on this edge

	// sequencer side, owns all addressing
	modport ctrl (
		output raddr, waddr, wdata, we,
		input  rdata
	);

	// memory side
	modport mem (
		input  raddr, waddr, wdata, we,
		output rdata
	);

	// row window only snoops the read data
	modport tap (
		input rdata
	);

endinterface

//--- include/life_settings.svh
//////////////////////////////
// board geometry and counter widths for the life engine
// include wherever the sizes are needed, guard makes repeats harmless
//////////////////////////////
`ifndef LIFE_SETTINGS_SVH
`define LIFE_SETTINGS_SVH

// cells per row, one full row goes through the datapath per cycle
`define LIFE_WIDTH 32

// rows per board, one bank of the row memory
`define LIFE_DEPTH 16

// row index width, must cover LIFE_DEPTH
`define LIFE_ADDR_BITS 4

// completed generations, wraps silently
`define LIFE_GEN_BITS 16

`endif

//--- tb.f
+incdir+include
design/life_pkg.sv
design/row_mem_if.sv
design/cell_bank_ram.sv
design/pass_sequencer.sv
design/life_row_update.sv
design/life_top.sv
testbench/tb_life.sv

//--- testbench/tb_life.sv
//////////////////////////////
// testbench for life_top covering host load, stepping and readback
// random boards checked against a toroidal board model
//////////////////////////////
`include "life_settings.svh"

module tb_life;
	timeunit 1ns;
	timeprecision 100ps;
	import life_pkg::*;

	localparam int DEPTH  = `LIFE_DEPTH;
	localparam int WIDTH  = `LIFE_WIDTH;
	localparam int BOARDS = 20;
	localparam int STEPS  = 5;
	// boards x (load + steps + readback) doubled for margin
	localparam int CYCLE_LIMIT = BOARDS * (DEPTH + STEPS * (DEPTH + 6) + DEPTH) * 2;

	logic       clk = 1'b0;
	logic       rst_n;
	logic       step;
	logic       busy;
	logic       done;
	gen_count_t gen_count;
	logic       wr_en;
	row_addr_t  wr_addr;
	row_t       wr_data;
	logic       rd_en;
	row_addr_t  rd_addr;
	logic       rd_valid;
	row_t       rd_data;

	row_t        model [DEPTH]; // reference board
	row_t        want  [DEPTH]; // expected readback
	gen_count_t  gen_exp;       // steps done so far
	logic [31:0] lcg = 32'd24291;
	int          cycle_cnt = 0;

	life_top UUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.step      (step),
		.busy      (busy),
		.done      (done),
		.gen_count (gen_count),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.rd_en     (rd_en),
		.rd_addr   (rd_addr),
		.rd_valid  (rd_valid),
		.rd_data   (rd_data)
	);

	always #4 clk = ~clk; // 8 ns period

	//////////////////////////////
	// random numbers and failure
	//////////////////////////////
	function automatic logic [31:0] lcg_next();
		lcg = lcg * 32'd1664525 + 32'd1013904223;
		return lcg;
	endfunction

	// upper halves only since low lcg bits are weak
	function automatic row_t rand_row();
		logic [31:0] a;
		logic [31:0] b;
		a = lcg_next();
		b = lcg_next();
		return row_t'({a[31:16], b[31:16]});
	endfunction

	task automatic fail_now();
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_row(input string name, input row_t exp, input row_t act);
		if (act !== exp) begin
			$display("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act);
			fail_now();
		end
	endtask

	task automatic check_gen(input string name, input gen_count_t exp, input gen_count_t act);
		if (act !== exp) begin
			$display("[ERROR] t=%0t %s expected %0d actual %0d", $time, name, exp, act);
			fail_now();
		end
	endtask

	task automatic check_flag(input string name, input bit exp, input bit act);
		if (act !== exp) begin
			$display("[ERROR] t=%0t %s expected %0b actual %0b", $time, name, exp, act);
			fail_now();
		end
	endtask

	// hard stop if the run stalls
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
			fail_now();
		end
	end

	//////////////////////////////
	// reference model
	//////////////////////////////
	// toroidal step with the center cell in the nine-sum
	task automatic model_step();
		row_t nxt [DEPTH];
		int   sum;
		int   rr;
		int   cc;
		for (int r = 0; r < DEPTH; r++) begin
			for (int c = 0; c < WIDTH; c++) begin
				sum = 0;
				for (int dr = -1; dr <= 1; dr++) begin
					for (int dc = -1; dc <= 1; dc++) begin
						rr = (r + dr + DEPTH) % DEPTH; // wrap top/bottom
						cc = (c + dc + WIDTH) % WIDTH; // wrap left/right
						sum += model[rr][cc];
					end
				end
				nxt[r][c] = (sum == 3) || (model[r][c] && (sum == 4));
			end
		end
		for (int r = 0; r < DEPTH; r++) begin
			model[r] = nxt[r];
		end
	endtask

	task automatic clear_model();
		for (int r = 0; r < DEPTH; r++) begin
			model[r] = '0;
		end
	endtask

	task automatic want_from_model();
		for (int r = 0; r < DEPTH; r++) begin
			want[r] = model[r];
		end
	endtask

	//////////////////////////////
	// host side
	//////////////////////////////
	// back-to-back writes of the model board
	task automatic write_board();
		for (int r = 0; r < DEPTH; r++) begin
			@(posedge clk);
			wr_en   <= 1'b1;
			wr_addr <= row_addr_t'(r);
			wr_data <= model[r];
		end
		@(posedge clk);
		wr_en <= 1'b0;
	endtask

	// isolated read checking the one cycle latency on both sides
	task automatic read_row_check(input row_addr_t a, input row_t exp);
		@(posedge clk);
		rd_en   <= 1'b1;
		rd_addr <= a;
		@(negedge clk);
		check_flag("rd_valid", 1'b0, rd_valid); // not before the sampling edge
		@(posedge clk);
		rd_en <= 1'b0;
		@(negedge clk);
		check_flag("rd_valid", 1'b1, rd_valid);
		check_row($sformatf("rd_data[%0d]", a), exp, rd_data);
	endtask

	// pipelined readback with read k-1 seen in slot k
	task automatic read_board();
		for (int k = 0; k <= DEPTH; k++) begin
			@(posedge clk);
			if (k < DEPTH) begin
				rd_en   <= 1'b1;
				rd_addr <= row_addr_t'(k);
			end else begin
				rd_en <= 1'b0;
			end
			@(negedge clk);
			if (k == 0) begin
				check_flag("rd_valid", 1'b0, rd_valid);
			end else begin
				check_flag("rd_valid", 1'b1, rd_valid);
				check_row($sformatf("rd_data[%0d]", k - 1), want[k - 1], rd_data);
			end
		end
	endtask

	// one generation with optional junk inputs while busy
	task automatic run_step(input bit noisy);
		logic [31:0] r;
		@(posedge clk);
		step <= 1'b1;
		@(posedge clk);
		step <= 1'b0; // accepting edge
		@(negedge clk);
		check_flag("busy", 1'b1, busy);
		check_flag("done", 1'b0, done);
		for (int n = 1; n <= DEPTH + 6; n++) begin
			@(posedge clk);
			if (noisy && (n <= DEPTH + 4)) begin
				r = lcg_next();
				step    <= r[20]; // all sampled while still busy
				wr_en   <= r[21];
				rd_en   <= r[22];
				wr_addr <= row_addr_t'(r[27:24]);
				rd_addr <= row_addr_t'(r[31:28]);
				wr_data <= rand_row();
			end else begin
				step  <= 1'b0;
				wr_en <= 1'b0;
				rd_en <= 1'b0;
			end
			@(negedge clk);
			check_flag("rd_valid", 1'b0, rd_valid);
			if (n < DEPTH + 5) begin
				check_flag("busy", 1'b1, busy);
				check_flag("done", 1'b0, done);
				check_gen("gen_count", gen_exp, gen_count); // no early bump
			end else if (n == DEPTH + 5) begin
				gen_exp = gen_exp + 1'b1;
				check_flag("done", 1'b1, done);
				check_flag("busy", 1'b0, busy);
				check_gen("gen_count", gen_exp, gen_count);
			end else begin
				check_flag("done", 1'b0, done); // single cycle pulse
				check_flag("busy", 1'b0, busy);
			end
		end
	endtask

	//////////////////////////////
	// test sequence
	//////////////////////////////
	initial begin
		rst_n   = 1'b0;
		step    = 1'b0;
		wr_en   = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		rd_en   = 1'b0;
		rd_addr = '0;
		gen_exp = '0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		// reset values
		@(negedge clk);
		check_flag("busy", 1'b0, busy);
		check_flag("done", 1'b0, done);
		check_flag("rd_valid", 1'b0, rd_valid);
		check_gen("gen_count", '0, gen_count);

		// host write then isolated reads
		for (int r = 0; r < DEPTH; r++) begin
			model[r] = rand_row();
		end
		write_board();
		for (int r = 0; r < DEPTH; r++) begin
			read_row_check(row_addr_t'(r), model[r]);
		end

		// blinker on row 5 across the column wrap (cols 31 0 1)
		clear_model();
		model[5] = (row_t'(1) << (WIDTH - 1)) | row_t'(3);
		write_board();
		run_step(1'b0);
		for (int r = 0; r < DEPTH; r++) begin
			want[r] = '0;
		end
		want[4] = row_t'(1); // vertical in column 0
		want[5] = row_t'(1);
		want[6] = row_t'(1);
		read_board();
		run_step(1'b0);
		want[4] = '0;
		want[5] = (row_t'(1) << (WIDTH - 1)) | row_t'(3);
		want[6] = '0;
		read_board();

		// glider heading down-right across the bottom edge
		clear_model();
		model[13] = row_t'(32'h4);
		model[14] = row_t'(32'h8);
		model[15] = row_t'(32'he);
		write_board();
		for (int s = 0; s < 8; s++) begin
			run_step(1'b0);
			model_step();
			want_from_model();
			read_board();
		end

		// random boards with junk inputs while busy on odd ones
		for (int b = 0; b < BOARDS; b++) begin
			for (int r = 0; r < DEPTH; r++) begin
				model[r] = rand_row();
			end
			write_board();
			for (int s = 0; s < STEPS; s++) begin
				run_step(b[0]);
				model_step();
				want_from_model();
				read_board();
			end
		end

		$display("sim passed");
		$finish;
	end

endmodule
